//--- pdl_pkg.sv
/* Shared definitions for the PDL buffer: word width, default depth,
   stack operation codes and the Wishbone register map. */

package pdl_pkg;

   // ======================================================================
   // Data path sizes
   // ======================================================================

   localparam int WORD_W = 32;               // One stack word.
   localparam int DEPTH_LOG2_DEFAULT = 10;   // 1024 words.

   // ======================================================================
   // Stack operations
   // ======================================================================

   typedef enum logic [1:0]
   {
      OP_PUSH      = 2'd0,
      OP_POP       = 2'd1,
      OP_READ_TOP  = 2'd2,
      OP_WRITE_TOP = 2'd3
   } pdl_op_t;

   // ======================================================================
   // Wishbone register map
   // ======================================================================

   // Word address. The top bit selects the register space, the bits
   // below it address the RAM window.
   localparam int WB_ADR_W = 11;
   localparam int WB_REG_BIT = WB_ADR_W - 1;

   localparam logic [WB_REG_BIT-1:0] REG_POINTER = 10'd0;  // Pointer and flags.
   localparam logic [WB_REG_BIT-1:0] REG_CONTROL = 10'd1;  // Pointer reload.

   // Flag positions in the REG_POINTER read word.
   localparam int STAT_OVERFLOW_BIT = 30;
   localparam int STAT_UNDERFLOW_BIT = 31;

endpackage

//--- pdl_port_if.sv
/* One port of the PDL RAM, with modports for the port's user and
   for the RAM itself. */

`timescale 1ns/1ps

interface pdl_port_if
#(
   parameter int ADDR_W = pdl_pkg::DEPTH_LOG2_DEFAULT
);

   logic [ADDR_W-1:0]         address;
   logic [pdl_pkg::WORD_W-1:0] wdata;
   logic                      wren;
   logic                      rden;
   logic [pdl_pkg::WORD_W-1:0] q;       // Registered read data.
   logic                      granted; // High when this cycle's write is performed.

   modport user
   (
      output address,
      output wdata,
      output wren,
      output rden,
      input  q,
      input  granted
   );

   modport ram
   (
      input  address,
      input  wdata,
      input  wren,
      input  rden,
      output q,
      output granted
   );

endinterface

//--- pdl_dpram.sv
/* Dual port synchronous RAM for the PDL, with registered reads that
   reset to zero and port A write priority. */

`timescale 1ns/1ps

module pdl_dpram
#(
   parameter int ADDR_W = pdl_pkg::DEPTH_LOG2_DEFAULT
)
(
   input logic clk_a,
   input logic reset,
   pdl_port_if.ram port_a,
   pdl_port_if.ram port_b
);

   localparam int WORDS = 1 << ADDR_W;

   logic [pdl_pkg::WORD_W-1:0] mem [0:WORDS-1];

   // ======================================================================
   // Write side
   // ======================================================================

   // Only one write per cycle reaches the array. Port B loses a collision.
   assign port_a.granted = port_a.wren;
   assign port_b.granted = port_b.wren && !port_a.wren;

   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
      begin
         mem[port_a.address] <= port_a.wdata;
      end
      else if (port_b.wren)
      begin
         mem[port_b.address] <= port_b.wdata;
      end
   end

   // ======================================================================
   // Read registers
   // ======================================================================

   // Reads sample the array before this edge's write lands, so a read
   // that meets a write on the other port sees the old word.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         port_a.q <= '0;
      end
      else if (port_a.rden)
      begin
         port_a.q <= mem[port_a.address];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         port_b.q <= '0;
      end
      else if (port_b.rden)
      begin
         port_b.q <= mem[port_b.address];
      end
   end

endmodule

//--- pdl_pointer.sv
/* PDL pointer: decodes stack operations, guards full and empty,
   drives RAM port A and keeps the sticky overflow and underflow flags. */

`timescale 1ns/1ps

module pdl_pointer
#(
   parameter int DEPTH_LOG2 = pdl_pkg::DEPTH_LOG2_DEFAULT
)
(
   input  logic                       clk_a,
   input  logic                       reset,
   input  pdl_pkg::pdl_op_t           op,
   input  logic                       op_valid,
   input  logic [pdl_pkg::WORD_W-1:0] push_data,
   output logic [pdl_pkg::WORD_W-1:0] top_data,
   output logic                       top_valid,
   output logic [DEPTH_LOG2:0]        pointer,
   output logic                       overflow,
   output logic                       underflow,
   input  logic                       pointer_load,
   input  logic [DEPTH_LOG2:0]        load_value,
   pdl_port_if.user                   port
);

   // Pointer value of a full stack.
   localparam logic [DEPTH_LOG2:0] FULL_COUNT = {1'b1, {DEPTH_LOG2{1'b0}}};

   logic              full;
   logic              empty;
   logic              take_op;
   logic              is_push;
   logic              is_pop;
   logic              is_read;
   logic              push_ok;
   logic              pop_ok;
   logic              read_ok;
   logic              write_ok;
   logic              push_err;
   logic              under_err;
   logic [DEPTH_LOG2:0] top_index;

   // ======================================================================
   // Operation decode
   // ======================================================================

   assign full  = (pointer == FULL_COUNT);
   assign empty = (pointer == '0);

   assign take_op = op_valid && !pointer_load;   // A reload wins over the stack.
   assign is_push = (op == pdl_pkg::OP_PUSH);
   assign is_pop  = (op == pdl_pkg::OP_POP);
   assign is_read = is_pop || (op == pdl_pkg::OP_READ_TOP);

   assign push_ok   = take_op && is_push && !full;
   assign pop_ok    = take_op && is_pop && !empty;
   assign read_ok   = take_op && is_read && !empty;
   assign write_ok  = take_op && (op == pdl_pkg::OP_WRITE_TOP) && !empty;
   assign push_err  = take_op && is_push && full;
   assign under_err = take_op && !is_push && empty;

   assign top_index = pointer - 1'b1;

   // RAM port A. Push writes above the top, all others work on the top word.
   assign port.address = is_push ? pointer[DEPTH_LOG2-1:0] : top_index[DEPTH_LOG2-1:0];
   assign port.wdata   = push_data;
   assign port.wren    = push_ok || write_ok;
   assign port.rden    = read_ok;

   assign top_data = port.q;

   // ======================================================================
   // Pointer, flags and read strobe
   // ======================================================================

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         pointer   <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
         top_valid <= 1'b0;
      end
      else if (pointer_load)
      begin
         pointer   <= load_value;
         overflow  <= 1'b0;
         underflow <= 1'b0;
         top_valid <= 1'b0;
      end
      else
      begin
         top_valid <= read_ok;   // q is loaded at this edge.
         if (push_ok)
            pointer <= pointer + 1'b1;
         else if (pop_ok)
            pointer <= top_index;
         if (push_err)
            overflow <= 1'b1;
         if (under_err)
            underflow <= 1'b1;
      end
   end

endmodule

//--- pdl_wb_slave.sv
/* Wishbone classic slave for the PDL: RAM window on port B, plus the
   pointer status and pointer reload registers. */

`timescale 1ns/1ps

module pdl_wb_slave
#(
   parameter int DEPTH_LOG2 = pdl_pkg::DEPTH_LOG2_DEFAULT
)
(
   input  logic                         clk_a,
   input  logic                         reset,
   input  logic [pdl_pkg::WB_ADR_W-1:0] wb_adr,
   input  logic [pdl_pkg::WORD_W-1:0]   wb_wdata,
   output logic [pdl_pkg::WORD_W-1:0]   wb_rdata,
   input  logic                         wb_we,
   input  logic                         wb_stb,
   input  logic                         wb_cyc,
   output logic                         wb_ack,
   input  logic [DEPTH_LOG2:0]          pointer,
   input  logic                         overflow,
   input  logic                         underflow,
   output logic                         pointer_load,
   output logic [DEPTH_LOG2:0]          load_value,
   pdl_port_if.user                     port
);

   typedef enum logic [1:0] {ST_IDLE, ST_RD_WAIT, ST_WR_RETRY, ST_ACK} state_t;

   state_t                     state;
   logic                       wb_req;
   logic                       reg_space;
   logic [pdl_pkg::WB_REG_BIT-1:0] reg_offset;
   logic [pdl_pkg::WORD_W-1:0] reg_rdata;
   logic                       new_req;

   assign wb_req     = wb_cyc && wb_stb;
   assign reg_space  = wb_adr[pdl_pkg::WB_REG_BIT];
   assign reg_offset = wb_adr[pdl_pkg::WB_REG_BIT-1:0];
   assign new_req    = wb_req && (state == ST_IDLE);

   // Status word for REG_POINTER. Other offsets read as zero.
   always_comb
   begin
      reg_rdata = '0;
      if (reg_offset == pdl_pkg::REG_POINTER)
      begin
         reg_rdata[DEPTH_LOG2:0] = pointer;
         reg_rdata[pdl_pkg::STAT_OVERFLOW_BIT] = overflow;
         reg_rdata[pdl_pkg::STAT_UNDERFLOW_BIT] = underflow;
      end
   end

   assign pointer_load = new_req && reg_space && wb_we && (reg_offset == pdl_pkg::REG_CONTROL);
   assign load_value   = wb_wdata[DEPTH_LOG2:0];

   // RAM port B. A write is offered until port A lets it through.
   assign port.address = wb_adr[DEPTH_LOG2-1:0];
   assign port.wdata   = wb_wdata;
   assign port.rden    = new_req && !reg_space && !wb_we;
   assign port.wren    = wb_req && !reg_space && wb_we &&
                         (state == ST_IDLE || state == ST_WR_RETRY);

   assign wb_ack = (state == ST_ACK);

   // ======================================================================
   // Cycle state machine
   // ======================================================================

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (wb_req)
               begin
                  if (reg_space)
                     state <= ST_ACK;
                  else if (!wb_we)
                     state <= ST_RD_WAIT;
                  else
                     state <= port.granted ? ST_ACK : ST_WR_RETRY;
               end
            ST_RD_WAIT:  state <= wb_req ? ST_ACK : ST_IDLE;
            ST_WR_RETRY:
               if (!wb_req)
                  state <= ST_IDLE;          // Master gave up.
               else if (port.granted)
                  state <= ST_ACK;
            default:     state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (new_req && reg_space && !wb_we)
         wb_rdata <= reg_rdata;
      else if (state == ST_RD_WAIT)
         wb_rdata <= port.q;   // RAM data arrived on the previous edge.
   end

endmodule

//--- pdl_buffer.sv
/* PDL buffer top level: stack pointer, Wishbone slave and dual port
   RAM, joined by two RAM port interfaces. */

`timescale 1ns/1ps

module pdl_buffer
#(
   parameter int DEPTH_LOG2 = pdl_pkg::DEPTH_LOG2_DEFAULT
)
(
   input  logic                         clk_a,
   input  logic                         reset,
   input  pdl_pkg::pdl_op_t             op,
   input  logic                         op_valid,
   input  logic [pdl_pkg::WORD_W-1:0]   push_data,
   output logic [pdl_pkg::WORD_W-1:0]   top_data,
   output logic                         top_valid,
   output logic                         overflow,
   output logic                         underflow,
   input  logic [pdl_pkg::WB_ADR_W-1:0] wb_adr,
   input  logic [pdl_pkg::WORD_W-1:0]   wb_wdata,
   output logic [pdl_pkg::WORD_W-1:0]   wb_rdata,
   input  logic                         wb_we,
   input  logic                         wb_stb,
   input  logic                         wb_cyc,
   output logic                         wb_ack
);

   logic [DEPTH_LOG2:0] pointer;
   logic                pointer_load;
   logic [DEPTH_LOG2:0] load_value;

   pdl_port_if #(.ADDR_W(DEPTH_LOG2)) port_a ();   // Stack side.
   pdl_port_if #(.ADDR_W(DEPTH_LOG2)) port_b ();   // Host side.

   pdl_dpram #(.ADDR_W(DEPTH_LOG2)) u_ram
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .port_a (port_a),
      .port_b (port_b)
   );

   pdl_pointer #(.DEPTH_LOG2(DEPTH_LOG2)) u_pointer
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .op           (op),
      .op_valid     (op_valid),
      .push_data    (push_data),
      .top_data     (top_data),
      .top_valid    (top_valid),
      .pointer      (pointer),
      .overflow     (overflow),
      .underflow    (underflow),
      .pointer_load (pointer_load),
      .load_value   (load_value),
      .port         (port_a)
   );

   pdl_wb_slave #(.DEPTH_LOG2(DEPTH_LOG2)) u_wb_slave
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .wb_adr       (wb_adr),
      .wb_wdata     (wb_wdata),
      .wb_rdata     (wb_rdata),
      .wb_we        (wb_we),
      .wb_stb       (wb_stb),
      .wb_cyc       (wb_cyc),
      .wb_ack       (wb_ack),
      .pointer      (pointer),
      .overflow     (overflow),
      .underflow    (underflow),
      .pointer_load (pointer_load),
      .load_value   (load_value),
      .port         (port_b)
   );

endmodule

//--- pdl_buffer_checker.sv
/* Concurrent assertions for the PDL buffer, bound into the top level:
   Wishbone acknowledge, top_valid timing and sticky flags. */

`timescale 1ns/1ps

module pdl_buffer_checker
#(
   parameter int DEPTH_LOG2 = pdl_pkg::DEPTH_LOG2_DEFAULT
)
(
   input logic                clk_a,
   input logic                reset,
   input pdl_pkg::pdl_op_t    op,
   input logic                op_valid,
   input logic [DEPTH_LOG2:0] pointer,
   input logic                pointer_load,
   input logic                top_valid,
   input logic                overflow,
   input logic                underflow,
   input logic                wb_cyc,
   input logic                wb_stb,
   input logic                wb_ack
);

   int unsigned fail_count = 0;
   logic        legal_read;

   // A pop or read top on a stack that holds words and is not overridden by a reload.
   assign legal_read = op_valid && !pointer_load && (pointer != '0) &&
                       (op == pdl_pkg::OP_POP || op == pdl_pkg::OP_READ_TOP);

   // ======================================================================
   // Wishbone handshake
   // ======================================================================

   ack_in_cycle: assert property (@(posedge clk_a) disable iff (reset)
      wb_ack |-> (wb_cyc && wb_stb))
      else
      begin
         $error("wb_ack seen outside an active Wishbone cycle.");
         fail_count++;
      end

   ack_single: assert property (@(posedge clk_a) disable iff (reset)
      wb_ack |=> !wb_ack)
      else
      begin
         $error("wb_ack held for two cycles in a row.");
         fail_count++;
      end

   // ======================================================================
   // Stack side
   // ======================================================================

   valid_follows_read: assert property (@(posedge clk_a) disable iff (reset)
      legal_read |=> top_valid)
      else
      begin
         $error("top_valid missing after a legal read.");
         fail_count++;
      end

   valid_only_after_read: assert property (@(posedge clk_a) disable iff (reset)
      top_valid |-> $past(legal_read))
      else
      begin
         $error("top_valid without a legal read before it.");
         fail_count++;
      end

   overflow_sticky: assert property (@(posedge clk_a) disable iff (reset)
      $fell(overflow) |-> $past(pointer_load))
      else
      begin
         $error("overflow cleared without a control write.");
         fail_count++;
      end

   underflow_sticky: assert property (@(posedge clk_a) disable iff (reset)
      $fell(underflow) |-> $past(pointer_load))
      else
      begin
         $error("underflow cleared without a control write.");
         fail_count++;
      end

endmodule

//--- tb_pdl_buffer.sv
/* Testbench for the PDL buffer: clock, reset, stack and Wishbone stimulus
   against stack and memory models, watchdog and result line. */

`timescale 1ns/1ps

module tb_pdl_buffer;

   localparam int DEPTH_LOG2 = 4;
   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam int CLK_PERIOD = 10;
   localparam int WB_MAX_WAIT = 32;
   localparam int TEST_CYCLES = 40 + 60 + 20 + 60 + 100;   // Rough length of all tests in cycles.

   logic                         clk_a;
   logic                         reset;
   pdl_pkg::pdl_op_t             op;
   logic                         op_valid;
   logic [pdl_pkg::WORD_W-1:0]   push_data;
   logic [pdl_pkg::WORD_W-1:0]   top_data;
   logic                         top_valid;
   logic                         overflow;
   logic                         underflow;
   logic [pdl_pkg::WB_ADR_W-1:0] wb_adr;
   logic [pdl_pkg::WORD_W-1:0]   wb_wdata;
   logic [pdl_pkg::WORD_W-1:0]   wb_rdata;
   logic                         wb_we;
   logic                         wb_stb;
   logic                         wb_cyc;
   logic                         wb_ack;

   logic [31:0] stack_q [$];   // Words below the pointer. The top word sits at the back.
   logic [31:0] mem_model [0:DEPTH-1];
   logic        overflow_model;
   logic        underflow_model;
   logic        pushes_done;
   int          error_count;
   integer      seed;
   string       test_name;

   pdl_buffer #(.DEPTH_LOG2(DEPTH_LOG2)) DUT (.*);

   bind pdl_buffer pdl_buffer_checker #(.DEPTH_LOG2(DEPTH_LOG2)) u_checker
   (
      .clk_a (clk_a), .reset (reset), .op (op), .op_valid (op_valid),
      .pointer (pointer), .pointer_load (pointer_load), .top_valid (top_valid),
      .overflow (overflow), .underflow (underflow),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_ack (wb_ack)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #(CLK_PERIOD / 2) clk_a = ~clk_a;
   end

   initial
   begin
      #(TEST_CYCLES * 2 * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run is stuck", TEST_CYCLES * 2);
      $display("Test failed");
      $finish;
   end

   // ======================================================================
   // Checks and bus tasks
   // ======================================================================

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("Error in %s, %s: expected 0x%08h, actual 0x%08h",
                  test_name, what, expected, actual);
         error_count++;
      end
   endtask

   // Issues one stack operation for the next rising edge and checks it in the cycle after.
   task automatic do_op(input pdl_pkg::pdl_op_t code, input logic [31:0] data);
      logic        expect_valid;
      logic [31:0] expect_data;
      expect_valid = 1'b0;
      expect_data  = '0;
      if (code == pdl_pkg::OP_PUSH)
      begin
         if (stack_q.size() == DEPTH)
            overflow_model = 1'b1;
         else
         begin
            mem_model[stack_q.size()] = data;
            stack_q.push_back(data);
         end
      end
      else if (stack_q.size() == 0)
         underflow_model = 1'b1;
      else if (code == pdl_pkg::OP_WRITE_TOP)
      begin
         stack_q[stack_q.size()-1] = data;
         mem_model[stack_q.size()-1] = data;
      end
      else
      begin
         expect_valid = 1'b1;
         expect_data  = stack_q[$];
         if (code == pdl_pkg::OP_POP)
            void'(stack_q.pop_back());
      end
      op        = code;
      op_valid  = 1'b1;
      push_data = data;
      @(negedge clk_a);
      op_valid = 1'b0;
      check_value("top_valid", 32'(expect_valid), 32'(top_valid));
      if (expect_valid)
         check_value("top_data", expect_data, top_data);
      check_value("overflow", 32'(overflow_model), 32'(overflow));
      check_value("underflow", 32'(underflow_model), 32'(underflow));
   endtask

   // Classic cycle; the master drops its strobe after the edge that sampled ack.
   task automatic wb_access(input logic [10:0] adr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      wb_adr   = adr;
      wb_we    = we;
      wb_wdata = wdata;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      waited   = 0;
      rdata    = '0;
      do
      begin
         @(negedge clk_a);
         waited++;
      end
      while (!wb_ack && waited < WB_MAX_WAIT);
      if (!wb_ack)
      begin
         $display("Error in %s: Wishbone cycle at 0x%03h got no acknowledge", test_name, adr);
         error_count++;
      end
      else
         rdata = wb_rdata;
      @(negedge clk_a);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read_ram(input int addr);
      logic [31:0] actual;
      wb_access({1'b0, 10'(addr)}, 1'b0, '0, actual);
      check_value($sformatf("RAM word %0d", addr), mem_model[addr], actual);
   endtask

   task automatic wb_write_ram(input int addr, input logic [31:0] data);
      logic [31:0] unused_rdata;
      wb_access({1'b0, 10'(addr)}, 1'b1, data, unused_rdata);
      mem_model[addr] = data;
      if (addr < stack_q.size())
         stack_q[addr] = data;
   endtask

   task automatic check_pointer_reg();
      logic [31:0] expected;
      logic [31:0] actual;
      expected = 32'(stack_q.size());
      expected[30] = overflow_model;
      expected[31] = underflow_model;
      wb_access({1'b1, pdl_pkg::REG_POINTER}, 1'b0, '0, actual);
      check_value("REG_POINTER", expected, actual);
   endtask

   // Reload the pointer; the stack model is rebuilt from the memory model.
   task automatic load_pointer(input int count);
      logic [31:0] unused_rdata;
      wb_access({1'b1, pdl_pkg::REG_CONTROL}, 1'b1, 32'(count), unused_rdata);
      overflow_model  = 1'b0;
      underflow_model = 1'b0;
      stack_q.delete();
      for (int i = 0; i < count; i++)
         stack_q.push_back(mem_model[i]);
   endtask

   // ======================================================================
   // Test sequence
   // ======================================================================

   initial
   begin
      seed = 32'h617b;
      error_count = 0;
      overflow_model = 1'b0;
      underflow_model = 1'b0;
      pushes_done = 1'b0;
      reset = 1'b1;
      op = pdl_pkg::OP_PUSH;
      op_valid = 1'b0;
      push_data = '0;
      wb_adr = '0;
      wb_wdata = '0;
      wb_we = 1'b0;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      repeat (4) @(negedge clk_a);
      reset = 1'b0;
      @(negedge clk_a);

      test_name = "reset_and_lifo";
      check_value("top_data", '0, top_data);
      check_value("top_valid", '0, 32'(top_valid));
      check_value("wb_ack", '0, 32'(wb_ack));
      check_value("overflow", '0, 32'(overflow));
      check_value("underflow", '0, 32'(underflow));
      check_pointer_reg();
      repeat (8) do_op(pdl_pkg::OP_PUSH, $random(seed));
      repeat (8) do_op(pdl_pkg::OP_POP, '0);

      test_name = "pointer_and_window";
      repeat (6) do_op(pdl_pkg::OP_PUSH, $random(seed));
      repeat (2) do_op(pdl_pkg::OP_POP, '0);
      check_pointer_reg();
      for (int i = 0; i < 6; i++)
         wb_read_ram(i);

      test_name = "host_and_stack_writes";
      wb_write_ram(stack_q.size() - 1, $random(seed));
      do_op(pdl_pkg::OP_READ_TOP, '0);
      do_op(pdl_pkg::OP_WRITE_TOP, $random(seed));
      wb_read_ram(stack_q.size() - 1);

      test_name = "overflow_underflow";
      while (stack_q.size() < DEPTH)
         do_op(pdl_pkg::OP_PUSH, $random(seed));
      do_op(pdl_pkg::OP_PUSH, $random(seed));   // One past full.
      check_pointer_reg();
      do_op(pdl_pkg::OP_READ_TOP, '0);
      load_pointer(0);
      check_pointer_reg();
      do_op(pdl_pkg::OP_POP, '0);
      do_op(pdl_pkg::OP_WRITE_TOP, $random(seed));
      check_pointer_reg();
      load_pointer(3);
      check_pointer_reg();
      do_op(pdl_pkg::OP_READ_TOP, '0);

      test_name = "write_under_push";
      load_pointer(0);
      fork
         begin
            repeat (8) do_op(pdl_pkg::OP_PUSH, $random(seed));
            pushes_done = 1'b1;
         end
         wb_write_ram(12, $random(seed));
         begin
            while (!wb_ack)
               @(negedge clk_a);
            check_value("pushes stopped before ack", 32'd1, 32'(pushes_done));
         end
      join
      for (int i = 0; i < 8; i++)
         wb_read_ram(i);
      wb_read_ram(12);
      check_pointer_reg();
      repeat (8) do_op(pdl_pkg::OP_POP, '0);

      $display("Run complete: %0d value errors, %0d assertion failures",
               error_count, DUT.u_checker.fail_count);
      if (error_count == 0 && DUT.u_checker.fail_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- pdl_buffer.f
pdl_pkg.sv
pdl_port_if.sv
pdl_dpram.sv
pdl_pointer.sv
pdl_wb_slave.sv
pdl_buffer.sv
pdl_buffer_checker.sv
tb_pdl_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PDL buffer testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_pdl_buffer -Mdir obj_dir -f pdl_buffer.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_pdl_buffer +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
